// ==== rvPkg.sv ====
// Widths, opcodes, ALU and FSM enums, mux selects, control and memory request structs
package rvPkg;

    localparam int XLen = 32;

    typedef logic [XLen-1:0] word_t;
    typedef logic [4:0]      regAddr_t;

    typedef enum logic [6:0] {
        Load  = 7'b0000011,
        Store = 7'b0100011,
        RType = 7'b0110011,
        IType = 7'b0010011,
        Jal   = 7'b1101111,
        Beq   = 7'b1100011
    } opcode_t;

    typedef enum logic [1:0] {
        AluOpAdd   = 2'b00,
        AluOpSub   = 2'b01,
        AluOpFunct = 2'b10    // Decode from funct fields
    } aluOp_t;

    typedef enum logic [2:0] {
        AluAdd = 3'b000,
        AluSub = 3'b001,
        AluAnd = 3'b010,
        AluOr  = 3'b011,
        AluSlt = 3'b101
    } aluCtrl_t;

    typedef enum logic [3:0] {
        Fetch,
        Decode,
        MemAdr,
        MemRead,
        MemWb,
        MemWrite,
        ExecuteR,
        AluWb,
        ExecuteI,
        JalS,
        BeqS
    } fsmState_t;

    typedef enum logic [1:0] {SrcAPc, SrcAOldPc, SrcAReg} srcASel_t;
    typedef enum logic [1:0] {SrcBWData, SrcBImm, SrcBFour} srcBSel_t;
    typedef enum logic [1:0] {ResAluOut, ResData, ResAluResult} resultSel_t;

    typedef struct packed {
        logic       pcWrite;
        logic       adrSrc;     // 0 PC, 1 result
        logic       irWrite;
        logic       regWrite;
        logic       memWrite;
        srcASel_t   srcA;
        srcBSel_t   srcB;
        resultSel_t resultSrc;
        aluCtrl_t   aluCtrl;
    } ctrl_t;

    typedef struct packed {
        logic  we;
        word_t adr;
        word_t wdata;
    } memReq_t;

endpackage

// ==== controlFsm.sv ====
// Multicycle control FSM with datapath selects, enables and PC write logic
`timescale 1ns/10ps

module controlFsm (
    input  logic          clk,
    input  logic          rst,
    input  rvPkg::word_t  instr,
    input  logic          zero,
    output rvPkg::aluOp_t aluOp,
    output rvPkg::ctrl_t  ctrl
);

    rvPkg::fsmState_t state;
    rvPkg::fsmState_t nextState;
    rvPkg::opcode_t   opcode;
    logic             branch;
    logic             pcUpdate;

    assign opcode = rvPkg::opcode_t'(instr[6:0]);

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            state <= rvPkg::Fetch;
        end else begin
            state <= nextState;
        end
    end

    always_comb begin
        ctrl           = '0;
        ctrl.srcA      = rvPkg::SrcAPc;
        ctrl.srcB      = rvPkg::SrcBWData;
        ctrl.resultSrc = rvPkg::ResAluOut;
        ctrl.aluCtrl   = rvPkg::AluAdd;   // Replaced by the ALU decoder output at top
        aluOp          = rvPkg::AluOpAdd;
        branch         = 1'b0;
        pcUpdate       = 1'b0;
        nextState      = rvPkg::Fetch;
        case (state)
            rvPkg::Fetch: begin
                ctrl.irWrite   = 1'b1;
                ctrl.srcB      = rvPkg::SrcBFour;
                ctrl.resultSrc = rvPkg::ResAluResult;   // PC + 4 straight back to PC
                pcUpdate       = 1'b1;
                nextState      = rvPkg::Decode;
            end
            rvPkg::Decode: begin
                // Branch and jump target lands in ALUOut
                ctrl.srcA = rvPkg::SrcAOldPc;
                ctrl.srcB = rvPkg::SrcBImm;
                case (opcode)
                    rvPkg::Load,
                    rvPkg::Store: nextState = rvPkg::MemAdr;
                    rvPkg::RType: nextState = rvPkg::ExecuteR;
                    rvPkg::IType: nextState = rvPkg::ExecuteI;
                    rvPkg::Jal:   nextState = rvPkg::JalS;
                    rvPkg::Beq:   nextState = rvPkg::BeqS;
                    default:      nextState = rvPkg::Fetch;
                endcase
            end
            rvPkg::MemAdr: begin
                ctrl.srcA = rvPkg::SrcAReg;
                ctrl.srcB = rvPkg::SrcBImm;
                nextState = (opcode == rvPkg::Load) ? rvPkg::MemRead : rvPkg::MemWrite;
            end
            rvPkg::MemRead: begin
                ctrl.adrSrc = 1'b1;
                nextState   = rvPkg::MemWb;
            end
            rvPkg::MemWb: begin
                ctrl.resultSrc = rvPkg::ResData;
                ctrl.regWrite  = 1'b1;
            end
            rvPkg::MemWrite: begin
                ctrl.adrSrc   = 1'b1;
                ctrl.memWrite = 1'b1;
            end
            rvPkg::ExecuteR: begin
                ctrl.srcA = rvPkg::SrcAReg;
                aluOp     = rvPkg::AluOpFunct;
                nextState = rvPkg::AluWb;
            end
            rvPkg::AluWb: begin
                ctrl.regWrite = 1'b1;
            end
            rvPkg::ExecuteI: begin
                ctrl.srcA = rvPkg::SrcAReg;
                ctrl.srcB = rvPkg::SrcBImm;
                aluOp     = rvPkg::AluOpFunct;
                nextState = rvPkg::AluWb;
            end
            rvPkg::JalS: begin
                // Target from ALUOut to PC, link value computed alongside
                ctrl.srcA = rvPkg::SrcAOldPc;
                ctrl.srcB = rvPkg::SrcBFour;
                pcUpdate  = 1'b1;
                nextState = rvPkg::AluWb;
            end
            rvPkg::BeqS: begin
                ctrl.srcA = rvPkg::SrcAReg;
                aluOp     = rvPkg::AluOpSub;
                branch    = 1'b1;
            end
            default: nextState = rvPkg::Fetch;
        endcase
        ctrl.pcWrite = pcUpdate | (branch & zero);
    end

    // Store and register write-back never in the same cycle
    assert property (@(posedge clk) disable iff (rst) !(ctrl.memWrite && ctrl.regWrite))
        else $error("memWrite and regWrite high together");

endmodule

// ==== aluDecoder.sv ====
// ALU decoder from operation class and function fields
`timescale 1ns/10ps

module aluDecoder (
    input  rvPkg::aluOp_t   aluOp,
    input  logic [2:0]      funct3,
    input  logic            opb5,
    input  logic            funct7b5,
    output rvPkg::aluCtrl_t aluCtrl
);

    always_comb begin
        case (aluOp)
            rvPkg::AluOpAdd: aluCtrl = rvPkg::AluAdd;
            rvPkg::AluOpSub: aluCtrl = rvPkg::AluSub;
            default: begin
                case (funct3)
                    // sub only for R-type with funct7 bit 5
                    3'b000:  aluCtrl = (opb5 && funct7b5) ? rvPkg::AluSub : rvPkg::AluAdd;
                    3'b010:  aluCtrl = rvPkg::AluSlt;
                    3'b110:  aluCtrl = rvPkg::AluOr;
                    3'b111:  aluCtrl = rvPkg::AluAnd;
                    default: aluCtrl = rvPkg::AluAdd;
                endcase
            end
        endcase
    end

endmodule

// ==== immExtend.sv ====
// Immediate extender selecting I, S, B or J format from the opcode
`timescale 1ns/10ps

module immExtend (
    input  rvPkg::word_t instr,
    output rvPkg::word_t imm
);

    rvPkg::opcode_t opcode;
    logic           sign;

    assign opcode = rvPkg::opcode_t'(instr[6:0]);
    assign sign   = instr[31];

    always_comb begin
        case (opcode)
            rvPkg::Store: begin
                imm = {{20{sign}}, instr[31:25], instr[11:7]};
            end
            rvPkg::Beq: begin
                imm = {{20{sign}}, instr[7], instr[30:25], instr[11:8], 1'b0};
            end
            rvPkg::Jal: begin
                imm = {{12{sign}}, instr[19:12], instr[20], instr[30:21], 1'b0};
            end
            default: begin
                imm = {{20{sign}}, instr[31:20]};   // I format, also lw
            end
        endcase
    end

endmodule

// ==== alu.sv ====
// ALU with add, sub, and, or, signed slt and zero flag
`timescale 1ns/10ps

module alu (
    input  rvPkg::word_t    srcA,
    input  rvPkg::word_t    srcB,
    input  rvPkg::aluCtrl_t aluCtrl,
    output rvPkg::word_t    result,
    output logic            zero
);

    logic lessThan;

    assign lessThan = $signed(srcA) < $signed(srcB);

    always_comb begin
        case (aluCtrl)
            rvPkg::AluAdd: result = srcA + srcB;
            rvPkg::AluSub: result = srcA - srcB;
            rvPkg::AluAnd: result = srcA & srcB;
            rvPkg::AluOr:  result = srcA | srcB;
            rvPkg::AluSlt: result = rvPkg::word_t'(lessThan);
            default:       result = '0;
        endcase
    end

    assign zero = (result == '0);   // Used by beq

endmodule

// ==== regFile.sv ====
// 32-entry register file, two combinational reads, x0 hardwired to zero
`timescale 1ns/10ps

module regFile (
    input  logic            clk,
    input  logic            rst,
    input  logic            we,
    input  rvPkg::regAddr_t rs1,
    input  rvPkg::regAddr_t rs2,
    input  rvPkg::regAddr_t rd,
    input  rvPkg::word_t    wd,
    output rvPkg::word_t    rd1,
    output rvPkg::word_t    rd2
);

    rvPkg::word_t regs [32];

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            for (int i = 0; i < 32; i++) begin
                regs[i] <= '0;
            end
        end else if (we && rd != '0) begin
            regs[rd] <= wd;
        end
    end

    assign rd1 = (rs1 == '0) ? '0 : regs[rs1];
    assign rd2 = (rs2 == '0) ? '0 : regs[rs2];

    // x0 must survive any write-back sequence
    assert property (@(posedge clk) regs[0] == '0)
        else $error("register x0 was modified");

endmodule

// ==== unifiedMemory.sv ====
// Unified instruction and data memory with combinational read and reset-time load port
`timescale 1ns/10ps

module unifiedMemory #(
    parameter int MemWords = 1024
) (
    input  logic           clk,
    input  logic           rst,
    input  rvPkg::memReq_t req,
    output rvPkg::word_t   rdata,
    input  logic           loadEn,
    input  rvPkg::word_t   loadAdr,
    input  rvPkg::word_t   loadData
);

    localparam int IdxW = $clog2(MemWords);

    rvPkg::word_t    mem [MemWords];
    logic [IdxW-1:0] reqIdx;
    logic [IdxW-1:0] loadIdx;

    assign reqIdx  = req.adr[IdxW+1:2];   // Word aligned
    assign loadIdx = loadAdr[IdxW+1:2];

    always_ff @(posedge clk) begin
        if (rst) begin
            if (loadEn) begin
                mem[loadIdx] <= loadData;
            end
        end else if (req.we) begin
            mem[reqIdx] <= req.wdata;
        end
    end

    assign rdata = mem[reqIdx];

    // Program load only while the core is held in reset
    assert property (@(posedge clk) loadEn |-> rst)
        else $error("loadEn high outside reset");

endmodule

// ==== datapath.sv ====
// Multicycle datapath with PC, IR, operand registers, muxes, register file, extender and ALU
`timescale 1ns/10ps

module datapath (
    input  logic           clk,
    input  logic           rst,
    input  rvPkg::ctrl_t   ctrl,
    output rvPkg::word_t   instr,
    output logic           zero,
    output rvPkg::memReq_t req,
    input  rvPkg::word_t   rdata
);

    rvPkg::word_t pc;
    rvPkg::word_t oldPc;
    rvPkg::word_t adr;
    rvPkg::word_t rd1;
    rvPkg::word_t rd2;
    rvPkg::word_t a;
    rvPkg::word_t wData;
    rvPkg::word_t data;
    rvPkg::word_t aluOut;
    rvPkg::word_t aluResult;
    rvPkg::word_t imm;
    rvPkg::word_t srcA;
    rvPkg::word_t srcB;
    rvPkg::word_t result;

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            pc <= '0;
        end else if (ctrl.pcWrite) begin
            pc <= result;
        end
    end

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            instr <= '0;
            oldPc <= '0;
        end else if (ctrl.irWrite) begin
            instr <= rdata;
            oldPc <= pc;   // PC of the fetched instruction
        end
    end

    // Stage registers, loaded every cycle
    always_ff @(posedge clk) begin
        a      <= rd1;
        wData  <= rd2;
        data   <= rdata;
        aluOut <= aluResult;
    end

    assign adr = ctrl.adrSrc ? result : pc;

    regFile uRegFile (
        .clk (clk),
        .rst (rst),
        .we  (ctrl.regWrite),
        .rs1 (instr[19:15]),
        .rs2 (instr[24:20]),
        .rd  (instr[11:7]),
        .wd  (result),
        .rd1 (rd1),
        .rd2 (rd2)
    );

    immExtend uImmExtend (
        .instr (instr),
        .imm   (imm)
    );

    always_comb begin
        case (ctrl.srcA)
            rvPkg::SrcAPc:    srcA = pc;
            rvPkg::SrcAOldPc: srcA = oldPc;
            default:          srcA = a;
        endcase
    end

    always_comb begin
        case (ctrl.srcB)
            rvPkg::SrcBWData: srcB = wData;
            rvPkg::SrcBImm:   srcB = imm;
            default:          srcB = rvPkg::word_t'(4);
        endcase
    end

    alu uAlu (
        .srcA    (srcA),
        .srcB    (srcB),
        .aluCtrl (ctrl.aluCtrl),
        .result  (aluResult),
        .zero    (zero)
    );

    always_comb begin
        case (ctrl.resultSrc)
            rvPkg::ResData:      result = data;
            rvPkg::ResAluResult: result = aluResult;
            default:             result = aluOut;
        endcase
    end

    assign req.we    = ctrl.memWrite;
    assign req.adr   = adr;
    assign req.wdata = wData;

endmodule

// ==== rvMulticycle.sv ====
// Top level of the multicycle RV32I core with controller, ALU decoder, datapath and memory
`timescale 1ns/10ps

module rvMulticycle #(
    parameter int MemWords = 1024
) (
    input  logic         clk,
    input  logic         rst,
    input  logic         loadEn,
    input  rvPkg::word_t loadAdr,
    input  rvPkg::word_t loadData,
    output logic         memWe,
    output rvPkg::word_t memAdr,
    output rvPkg::word_t memWData
);

    rvPkg::ctrl_t    fsmCtrl;
    rvPkg::ctrl_t    dpCtrl;
    rvPkg::aluOp_t   aluOp;
    rvPkg::aluCtrl_t aluCtrl;
    rvPkg::word_t    instr;
    rvPkg::word_t    rdata;
    rvPkg::memReq_t  req;
    logic            zero;

    controlFsm uControl (
        .clk   (clk),
        .rst   (rst),
        .instr (instr),
        .zero  (zero),
        .aluOp (aluOp),
        .ctrl  (fsmCtrl)
    );

    aluDecoder uAluDecoder (
        .aluOp    (aluOp),
        .funct3   (instr[14:12]),
        .opb5     (instr[5]),
        .funct7b5 (instr[30]),
        .aluCtrl  (aluCtrl)
    );

    always_comb begin
        dpCtrl         = fsmCtrl;
        dpCtrl.aluCtrl = aluCtrl;
    end

    datapath uDatapath (
        .clk   (clk),
        .rst   (rst),
        .ctrl  (dpCtrl),
        .instr (instr),
        .zero  (zero),
        .req   (req),
        .rdata (rdata)
    );

    unifiedMemory #(
        .MemWords (MemWords)
    ) uMemory (
        .clk      (clk),
        .rst      (rst),
        .req      (req),
        .rdata    (rdata),
        .loadEn   (loadEn),
        .loadAdr  (loadAdr),
        .loadData (loadData)
    );

    assign memWe    = req.we;
    assign memAdr   = req.adr;
    assign memWData = req.wdata;

endmodule

// ==== tbRvMulticycle.sv ====
// Testbench for the multicycle RV32I core: program load, run and store checks
`timescale 1ns/10ps

module tbRvMulticycle;

    localparam int NameBits     = 8 * 24;
    localparam int ResetCycles  = 5;
    localparam int MarginCycles = 20;
    localparam int CyclesPerIns = 5;   // Longest instruction is lw
    localparam int DriveDelay   = 2;

    logic         clk;
    logic         rst;
    logic         loadEn;
    rvPkg::word_t loadAdr;
    rvPkg::word_t loadData;
    logic         memWe;
    rvPkg::word_t memAdr;
    rvPkg::word_t memWData;

    rvPkg::word_t        loadAdrQ [$];
    rvPkg::word_t        loadDataQ [$];
    rvPkg::word_t        expAdrQ [$];
    rvPkg::word_t        expDataQ [$];
    logic [NameBits-1:0] expNameQ [$];

    int instrCount;
    bit stimLoaded;
    int storeCount;
    int resetWeCount;
    int passCount;
    int failCount;

    rvMulticycle #(
        .MemWords (1024)
    ) DUT (
        .clk      (clk),
        .rst      (rst),
        .loadEn   (loadEn),
        .loadAdr  (loadAdr),
        .loadData (loadData),
        .memWe    (memWe),
        .memAdr   (memAdr),
        .memWData (memWData)
    );

    initial begin
        clk = 1'b0;
        forever #20 clk = ~clk;
    end

    // Line tags are # comment, L load word, E expected store and N instruction count
    task automatic readStimulus(output bit ok);
        int                  fd;
        int                  code;
        byte                 tag;
        rvPkg::word_t        adrVal;
        rvPkg::word_t        dataVal;
        logic [NameBits-1:0] nameVal;
        logic [8*128-1:0]    lineBuf;
        ok = 1'b1;
        fd = $fopen("rvStimulus.txt", "r");
        if (fd == 0) begin
            $display("Could not open the stimulus file rvStimulus.txt");
            ok = 1'b0;
            return;
        end
        while (!$feof(fd)) begin
            code = $fscanf(fd, " %c", tag);
            if (code != 1) begin
                break;
            end
            case (tag)
                "#": code = $fgets(lineBuf, fd);
                "L": begin
                    code = $fscanf(fd, "%h %h", adrVal, dataVal);
                    loadAdrQ.push_back(adrVal);
                    loadDataQ.push_back(dataVal);
                end
                "E": begin
                    code = $fscanf(fd, "%h %h %s", adrVal, dataVal, nameVal);
                    expAdrQ.push_back(adrVal);
                    expDataQ.push_back(dataVal);
                    expNameQ.push_back(nameVal);
                end
                "N": code = $fscanf(fd, "%d", instrCount);
                default: begin
                    $display("Unknown line tag in the stimulus file");
                    ok = 1'b0;
                end
            endcase
        end
        $fclose(fd);
        if (expAdrQ.size() == 0 || instrCount == 0) begin
            $display("Stimulus file holds no expected stores or no instruction count");
            ok = 1'b0;
        end
    endtask

    // Compare each store in order against the next expected one
    task automatic checkStore(input rvPkg::word_t adr, input rvPkg::word_t data);
        if (storeCount >= expAdrQ.size()) begin
            $display("Unexpected store of %h to %h after the last expected store", data, adr);
            failCount++;
        end else if (adr !== expAdrQ[storeCount] || data !== expDataQ[storeCount]) begin
            $display("FAILED %0s expected %h @ %h actual %h @ %h", expNameQ[storeCount],
                     expDataQ[storeCount], expAdrQ[storeCount], data, adr);
            failCount++;
        end else begin
            $display("PASSED %0s %h @ %h", expNameQ[storeCount], data, adr);
            passCount++;
        end
        storeCount++;
    endtask

    // memWe holds for a whole cycle, so the falling edge sees it settled
    always @(negedge clk) begin
        if (memWe) begin
            if (rst) begin
                resetWeCount++;
            end else begin
                checkStore(memAdr, memWData);
            end
        end
    end

    initial begin
        bit ok;
        rst      = 1'b1;
        loadEn   = 1'b0;
        loadAdr  = '0;
        loadData = '0;
        readStimulus(ok);
        stimLoaded = 1'b1;
        if (!ok) begin
            $display(">>> FAIL");
            $finish;
        end else begin
            foreach (loadAdrQ[i]) begin   // One word per cycle
                @(posedge clk);
                #DriveDelay;
                loadEn   = 1'b1;
                loadAdr  = loadAdrQ[i];
                loadData = loadDataQ[i];
            end
            @(posedge clk);
            #DriveDelay;
            loadEn = 1'b0;
            repeat (ResetCycles) @(posedge clk);
            #DriveDelay;
            rst = 1'b0;
            if (resetWeCount == 0) begin
                $display("PASSED reset_no_store");
                passCount++;
            end else begin
                $display("Test reset_no_store: memWe rose %0d times while rst was high",
                         resetWeCount);
                failCount++;
            end
            wait (storeCount >= expAdrQ.size());
            @(negedge clk);
            $display("Tests passed %0d, failed %0d, stores seen %0d of %0d",
                     passCount, failCount, storeCount, expAdrQ.size());
            if (failCount == 0) begin
                $display(">>> PASS");
            end else begin
                $display(">>> FAIL");
            end
            $finish;
        end
    end

    // Watchdog sized from the program length
    initial begin
        int limit;
        wait (stimLoaded);
        limit = instrCount * CyclesPerIns + loadAdrQ.size() + ResetCycles + MarginCycles;
        repeat (limit) @(posedge clk);
        $display("Timeout after %0d cycles: only %0d of %0d expected stores were seen",
                 limit, storeCount, expAdrQ.size());
        $display(">>> FAIL");
        $finish;
    end

endmodule

// ==== rvMulticycle.f ====
rvPkg.sv
controlFsm.sv
aluDecoder.sv
immExtend.sv
alu.sv
regFile.sv
unifiedMemory.sv
datapath.sv
rvMulticycle.sv
tbRvMulticycle.sv

// ==== Bender.yml ====
package:
  name: rvMulticycle

sources:
  - rvPkg.sv
  - controlFsm.sv
  - aluDecoder.sv
  - immExtend.sv
  - alu.sv
  - regFile.sv
  - unifiedMemory.sv
  - datapath.sv
  - rvMulticycle.sv
  - target: simulation
    files:
      - tbRvMulticycle.sv

// ==== rvStimulus.txt ====
# L load_address load_word | E store_address store_data test_name
# N executed_instruction_count up to the last store
L 00000000 06C00093
L 00000004 FF900113
L 00000008 002081B3
L 0000000C 20302023
L 00000010 40208233
L 00000014 20402223
L 00000018 0020F2B3
L 0000001C 20502423
L 00000020 0020E333
L 00000024 20602623
L 00000028 001123B3
L 0000002C 20702823
L 00000030 10002403
L 00000034 20802A23
L 00000038 00108463
L 0000003C 2E102823
L 00000040 00208463
L 00000044 20202C23
L 00000048 008004EF
L 0000004C 2E102A23
L 00000050 20902E23
L 00000054 07B00013
L 00000058 22002023
L 0000005C 0000006F
L 00000100 CAFEF00D
E 00000200 00000065 add
E 00000204 00000073 sub
E 00000208 00000068 and
E 0000020C FFFFFFFD or
E 00000210 00000001 slt_negative
E 00000214 CAFEF00D lw_copy
E 00000218 FFFFFFF9 beq_not_taken
E 0000021C 0000004C jal_link
E 00000220 00000000 x0_write
N 21
